// ==== hw/rv_pkg.sv ====
package rv_pkg;

  // datapath and memory sizing
  localparam int xlen        = 32;
  localparam int reg_addr_w  = 5;
  localparam int imem_words  = 64;
  localparam int imem_addr_w = 6;

  typedef logic [xlen-1:0]       word_t;
  typedef logic [reg_addr_w-1:0] reg_addr_t;

  // major opcodes of the supported instruction groups
  localparam logic [6:0] opc_lui     = 7'b0110111;
  localparam logic [6:0] opc_reg_imm = 7'b0010011;
  localparam logic [6:0] opc_reg_reg = 7'b0110011;
  localparam logic [6:0] opc_jal     = 7'b1101111;
  localparam logic [6:0] opc_jalr    = 7'b1100111;
  localparam logic [6:0] opc_branch  = 7'b1100011;
  localparam logic [6:0] opc_environ = 7'b1110011;

  // funct7 of sub, sra and srai
  localparam logic [6:0] funct7_alt = 7'b0100000;

  // what the writeback stage holds in a given cycle
  typedef enum logic [2:0] {
    invalid      = 3'd0,
    reset        = 3'd1,
    no_stall     = 3'd2,
    taken_branch = 3'd4
  } cycle_status_e;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    cycle_status_e status;
  } decode_stage_t;

  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         a;
    word_t         b;
    cycle_status_e status;
  } execute_stage_t;

  // shared by the memory and writeback stage registers
  typedef struct packed {
    word_t         pc;
    word_t         insn;
    word_t         result;
    logic          we;
    logic          illegal;
    cycle_status_e status;
  } result_stage_t;

  // source of an execute operand
  typedef enum logic [1:0] {
    fwd_rf  = 2'd0,
    fwd_mem = 2'd1,
    fwd_wb  = 2'd2
  } fwd_sel_e;

endpackage

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         imem_we,
  input  logic [rv_pkg::imem_addr_w-1:0] imem_addr,
  input  rv_pkg::word_t                imem_data,
  input  logic                         redirect,
  input  rv_pkg::word_t                redirect_pc,
  output rv_pkg::word_t                pc,
  output rv_pkg::word_t                insn
);

  rv_pkg::word_t imem [rv_pkg::imem_words];

  // program load port, usable while the core sits in reset
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr] <= imem_data;
    end
  end

  // next pc is either sequential or the resolved target from execute
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else begin
      pc <= pc + 32'd4;
    end
  end

  // word addressed, low two pc bits dropped
  assign insn = imem[pc[rv_pkg::imem_addr_w+1:2]];

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::word_t     rs1_data,
  output rv_pkg::word_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::word_t     rd_data
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      regs[rd] <= rd_data;
    end
  end

endmodule

// ==== hw/execute_alu.sv ====
`timescale 1ns/1ps

module execute_alu (
  input  rv_pkg::execute_stage_t ex_stage,
  input  rv_pkg::fwd_sel_e       fwd_a,
  input  rv_pkg::fwd_sel_e       fwd_b,
  input  rv_pkg::word_t          mem_result,
  input  rv_pkg::word_t          wb_result,
  output rv_pkg::word_t          result,
  output logic                   result_we,
  output logic                   illegal,
  output logic                   redirect,
  output rv_pkg::word_t          redirect_pc
);

  logic [6:0]    opcode;
  logic [6:0]    funct7;
  logic [2:0]    funct3;
  logic          alt;
  logic          taken;
  logic [4:0]    shamt;
  rv_pkg::word_t op_a;
  rv_pkg::word_t op_b;
  rv_pkg::word_t alu_b;
  rv_pkg::word_t alu_out;
  rv_pkg::word_t imm_i;
  rv_pkg::word_t imm_b;
  rv_pkg::word_t imm_j;
  rv_pkg::word_t link_pc;

  assign opcode = ex_stage.insn[6:0];
  assign funct3 = ex_stage.insn[14:12];
  assign funct7 = ex_stage.insn[31:25];
  assign alt    = (funct7 == rv_pkg::funct7_alt);

  assign imm_i = {{20{ex_stage.insn[31]}}, ex_stage.insn[31:20]};
  assign imm_b = {{20{ex_stage.insn[31]}}, ex_stage.insn[7], ex_stage.insn[30:25],
                  ex_stage.insn[11:8], 1'b0};
  assign imm_j = {{12{ex_stage.insn[31]}}, ex_stage.insn[19:12], ex_stage.insn[20],
                  ex_stage.insn[30:21], 1'b0};
  assign link_pc = ex_stage.pc + 32'd4;

  // memory stage holds the newer result, so it wins over writeback
  always_comb begin
    case (fwd_a)
      rv_pkg::fwd_mem: op_a = mem_result;
      rv_pkg::fwd_wb:  op_a = wb_result;
      default:         op_a = ex_stage.a;
    endcase
    case (fwd_b)
      rv_pkg::fwd_mem: op_b = mem_result;
      rv_pkg::fwd_wb:  op_b = wb_result;
      default:         op_b = ex_stage.b;
    endcase
  end

  // one ALU for both reg-imm and reg-reg forms
  assign alu_b = (opcode == rv_pkg::opc_reg_imm) ? imm_i : op_b;
  assign shamt = alu_b[4:0];

  always_comb begin
    case (funct3)
      3'b000:  alu_out = (opcode == rv_pkg::opc_reg_reg && alt) ? op_a - alu_b : op_a + alu_b;
      3'b001:  alu_out = op_a << shamt;
      3'b010:  alu_out = {31'd0, $signed(op_a) < $signed(alu_b)};
      3'b011:  alu_out = {31'd0, op_a < alu_b};
      3'b100:  alu_out = op_a ^ alu_b;
      3'b101:  alu_out = alt ? rv_pkg::word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
      3'b110:  alu_out = op_a | alu_b;
      default: alu_out = op_a & alu_b;
    endcase
  end

  // branch condition from funct3
  always_comb begin
    case (funct3)
      3'b000:  taken = (op_a == op_b);
      3'b001:  taken = (op_a != op_b);
      3'b100:  taken = ($signed(op_a) < $signed(op_b));
      3'b101:  taken = ($signed(op_a) >= $signed(op_b));
      3'b110:  taken = (op_a < op_b);
      default: taken = (op_a >= op_b);
    endcase
  end

  always_comb begin
    result      = alu_out;
    result_we   = 1'b0;
    illegal     = 1'b0;
    redirect    = 1'b0;
    redirect_pc = ex_stage.pc + imm_b;
    case (opcode)
      rv_pkg::opc_lui: begin
        result    = {ex_stage.insn[31:12], 12'd0};
        result_we = 1'b1;
      end
      rv_pkg::opc_reg_imm: begin
        // shifts by immediate only allow the funct7 patterns of slli, srli and srai
        if ((funct3 == 3'b001 && funct7 != 7'd0) ||
            (funct3 == 3'b101 && funct7 != 7'd0 && !alt)) begin
          illegal = 1'b1;
        end else begin
          result_we = 1'b1;
        end
      end
      rv_pkg::opc_reg_reg: begin
        if (funct7 == 7'd0 || (alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          result_we = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      rv_pkg::opc_branch: begin
        if (funct3 == 3'b010 || funct3 == 3'b011) begin
          illegal = 1'b1;
        end else begin
          redirect = taken;
        end
      end
      rv_pkg::opc_jal: begin
        result      = link_pc;
        result_we   = 1'b1;
        redirect    = 1'b1;
        redirect_pc = ex_stage.pc + imm_j;
      end
      rv_pkg::opc_jalr: begin
        if (funct3 == 3'b000) begin
          result      = link_pc;
          result_we   = 1'b1;
          redirect    = 1'b1;
          redirect_pc = (op_a + imm_i) & ~32'd1;
        end else begin
          illegal = 1'b1;
        end
      end
      rv_pkg::opc_environ: begin
        // ecall only, it has no result
        illegal = (ex_stage.insn[31:7] != 25'd0);
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== hw/pipe_control.sv ====
`timescale 1ns/1ps

module pipe_control (
  input  logic                   clk,
  input  logic                   rst,
  input  rv_pkg::word_t          fetch_pc,
  input  rv_pkg::word_t          fetch_insn,
  output rv_pkg::reg_addr_t      rf_rs1,
  output rv_pkg::reg_addr_t      rf_rs2,
  input  rv_pkg::word_t          rf_rs1_data,
  input  rv_pkg::word_t          rf_rs2_data,
  output logic                   rf_we,
  output rv_pkg::reg_addr_t      rf_rd,
  output rv_pkg::word_t          rf_wdata,
  output rv_pkg::execute_stage_t ex_stage,
  output rv_pkg::fwd_sel_e       fwd_a,
  output rv_pkg::fwd_sel_e       fwd_b,
  output rv_pkg::word_t          mem_result,
  output rv_pkg::word_t          wb_result,
  input  rv_pkg::word_t          ex_result,
  input  logic                   ex_we,
  input  logic                   ex_illegal,
  input  logic                   redirect,
  output logic                   halt,
  output rv_pkg::word_t          trace_pc,
  output rv_pkg::word_t          trace_insn,
  output rv_pkg::cycle_status_e  trace_status,
  output logic                   trace_we,
  output rv_pkg::reg_addr_t      trace_rd,
  output rv_pkg::word_t          trace_data
);

  rv_pkg::decode_stage_t  dec_q;
  rv_pkg::execute_stage_t ex_q;
  rv_pkg::result_stage_t  mem_q;
  rv_pkg::result_stage_t  wb_q;
  rv_pkg::word_t          dec_a;
  rv_pkg::word_t          dec_b;
  rv_pkg::reg_addr_t      ex_rs1;
  rv_pkg::reg_addr_t      ex_rs2;
  rv_pkg::reg_addr_t      mem_rd;
  rv_pkg::reg_addr_t      wb_rd;

  assign rf_rs1 = dec_q.insn[19:15];
  assign rf_rs2 = dec_q.insn[24:20];
  assign ex_rs1 = ex_q.insn[19:15];
  assign ex_rs2 = ex_q.insn[24:20];
  assign mem_rd = mem_q.insn[11:7];
  assign wb_rd  = wb_q.insn[11:7];

  // register file writes at the edge, so a same-cycle read takes the writeback value
  assign dec_a = (wb_q.we && wb_rd == rf_rs1) ? wb_q.result : rf_rs1_data;
  assign dec_b = (wb_q.we && wb_rd == rf_rs2) ? wb_q.result : rf_rs2_data;

  always_comb begin
    if (mem_q.we && mem_rd == ex_rs1) begin
      fwd_a = rv_pkg::fwd_mem;
    end else if (wb_q.we && wb_rd == ex_rs1) begin
      fwd_a = rv_pkg::fwd_wb;
    end else begin
      fwd_a = rv_pkg::fwd_rf;
    end
    if (mem_q.we && mem_rd == ex_rs2) begin
      fwd_b = rv_pkg::fwd_mem;
    end else if (wb_q.we && wb_rd == ex_rs2) begin
      fwd_b = rv_pkg::fwd_wb;
    end else begin
      fwd_b = rv_pkg::fwd_rf;
    end
  end

  // a redirect squashes the two younger instructions in fetch and decode
  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pkg::reset};
      ex_q  <= '{pc: '0, insn: '0, a: '0, b: '0, status: rv_pkg::reset};
    end else if (redirect) begin
      dec_q <= '{pc: '0, insn: '0, status: rv_pkg::taken_branch};
      ex_q  <= '{pc: '0, insn: '0, a: '0, b: '0, status: rv_pkg::taken_branch};
    end else begin
      dec_q <= '{pc: fetch_pc, insn: fetch_insn, status: rv_pkg::no_stall};
      ex_q  <= '{pc: dec_q.pc, insn: dec_q.insn, a: dec_a, b: dec_b, status: dec_q.status};
    end
  end

  // x0 writes are dropped here so nothing downstream forwards or stores them
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_q <= '{pc: '0, insn: '0, result: '0, we: 1'b0, illegal: 1'b0,
                 status: rv_pkg::reset};
      wb_q  <= '{pc: '0, insn: '0, result: '0, we: 1'b0, illegal: 1'b0,
                 status: rv_pkg::reset};
    end else begin
      mem_q <= '{pc: ex_q.pc, insn: ex_q.insn, result: ex_result,
                 we: ex_we && (ex_q.insn[11:7] != '0),
                 illegal: ex_illegal && (ex_q.status == rv_pkg::no_stall),
                 status: ex_q.status};
      wb_q  <= mem_q;
    end
  end

  assign ex_stage   = ex_q;
  assign mem_result = mem_q.result;
  assign wb_result  = wb_q.result;

  assign rf_we    = wb_q.we;
  assign rf_rd    = wb_rd;
  assign rf_wdata = wb_q.result;

  assign halt = (wb_q.status == rv_pkg::no_stall) && (wb_q.insn == {25'd0, rv_pkg::opc_environ});

  // illegal instructions show up with pc and insn cleared
  assign trace_pc     = wb_q.illegal ? '0 : wb_q.pc;
  assign trace_insn   = wb_q.illegal ? '0 : wb_q.insn;
  assign trace_status = wb_q.status;
  assign trace_we     = wb_q.we;
  assign trace_rd     = wb_rd;
  assign trace_data   = wb_q.result;

endmodule

// ==== hw/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           imem_we,
  input  logic [rv_pkg::imem_addr_w-1:0] imem_addr,
  input  rv_pkg::word_t                  imem_data,
  output logic                           halt,
  output rv_pkg::word_t                  trace_pc,
  output rv_pkg::word_t                  trace_insn,
  output rv_pkg::cycle_status_e          trace_status,
  output logic                           trace_we,
  output rv_pkg::reg_addr_t              trace_rd,
  output rv_pkg::word_t                  trace_data
);

  rv_pkg::word_t          fetch_pc;
  rv_pkg::word_t          fetch_insn;
  logic                   redirect;
  rv_pkg::word_t          redirect_pc;
  rv_pkg::reg_addr_t      rf_rs1;
  rv_pkg::reg_addr_t      rf_rs2;
  rv_pkg::word_t          rf_rs1_data;
  rv_pkg::word_t          rf_rs2_data;
  logic                   rf_we;
  rv_pkg::reg_addr_t      rf_rd;
  rv_pkg::word_t          rf_wdata;
  rv_pkg::execute_stage_t ex_stage;
  rv_pkg::fwd_sel_e       fwd_a;
  rv_pkg::fwd_sel_e       fwd_b;
  rv_pkg::word_t          mem_result;
  rv_pkg::word_t          wb_result;
  rv_pkg::word_t          ex_result;
  logic                   ex_we;
  logic                   ex_illegal;

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .imem_we     (imem_we),
    .imem_addr   (imem_addr),
    .imem_data   (imem_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pc          (fetch_pc),
    .insn        (fetch_insn)
  );

  reg_file u_rf (
    .clk      (clk),
    .rst      (rst),
    .rs1      (rf_rs1),
    .rs2      (rf_rs2),
    .rs1_data (rf_rs1_data),
    .rs2_data (rf_rs2_data),
    .we       (rf_we),
    .rd       (rf_rd),
    .rd_data  (rf_wdata)
  );

  execute_alu u_alu (
    .ex_stage    (ex_stage),
    .fwd_a       (fwd_a),
    .fwd_b       (fwd_b),
    .mem_result  (mem_result),
    .wb_result   (wb_result),
    .result      (ex_result),
    .result_we   (ex_we),
    .illegal     (ex_illegal),
    .redirect    (redirect),
    .redirect_pc (redirect_pc)
  );

  pipe_control u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .fetch_pc     (fetch_pc),
    .fetch_insn   (fetch_insn),
    .rf_rs1       (rf_rs1),
    .rf_rs2       (rf_rs2),
    .rf_rs1_data  (rf_rs1_data),
    .rf_rs2_data  (rf_rs2_data),
    .rf_we        (rf_we),
    .rf_rd        (rf_rd),
    .rf_wdata     (rf_wdata),
    .ex_stage     (ex_stage),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .mem_result   (mem_result),
    .wb_result    (wb_result),
    .ex_result    (ex_result),
    .ex_we        (ex_we),
    .ex_illegal   (ex_illegal),
    .redirect     (redirect),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_we     (trace_we),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data)
  );

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 40 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule

// ==== test/tb_riscv_core.sv ====
`timescale 1ns/1ps

module tb_riscv_core;

  typedef struct packed {
    rv_pkg::word_t         pc;
    rv_pkg::word_t         insn;
    rv_pkg::cycle_status_e status;
    logic                  we;
    rv_pkg::reg_addr_t     rd;
    rv_pkg::word_t         data;
    logic                  halt;
  } trace_entry_t;

  logic                           clk;
  logic                           rst;
  logic                           imem_we;
  logic [rv_pkg::imem_addr_w-1:0] imem_addr;
  rv_pkg::word_t                  imem_data;
  logic                           halt;
  rv_pkg::word_t                  trace_pc;
  rv_pkg::word_t                  trace_insn;
  rv_pkg::cycle_status_e          trace_status;
  logic                           trace_we;
  rv_pkg::reg_addr_t              trace_rd;
  rv_pkg::word_t                  trace_data;

  rv_pkg::word_t prog[$];
  trace_entry_t  exp_q[$];

  tb_clock u_clock (.clk(clk));

  riscv_core uut (
    .clk          (clk),
    .rst          (rst),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .halt         (halt),
    .trace_pc     (trace_pc),
    .trace_insn   (trace_insn),
    .trace_status (trace_status),
    .trace_we     (trace_we),
    .trace_rd     (trace_rd),
    .trace_data   (trace_data)
  );

  task automatic stop_failed();
    $display("TB FAILED");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic fail_with_reason(input string what);
    $display("[ERROR] time %0t: %s", $time, what);
    stop_failed();
  endtask

  task automatic check_word(input string name, input rv_pkg::word_t exp, input rv_pkg::word_t act);
    if (act !== exp) begin
      $display("[FAIL] time %0t %s expected %h actual %h", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_reg(input string name, input rv_pkg::reg_addr_t exp,
                           input rv_pkg::reg_addr_t act);
    if (act !== exp) begin
      $display("[FAIL] time %0t %s expected x%0d actual x%0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_status(input string name, input rv_pkg::cycle_status_e exp,
                              input rv_pkg::cycle_status_e act);
    if (act !== exp) begin
      $display("[FAIL] time %0t %s expected %0d actual %0d", $time, name, exp, act);
      stop_failed();
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] time %0t %s expected %b actual %b", $time, name, exp, act);
      stop_failed();
    end
  endtask

  // RV32I encoders
  function automatic rv_pkg::word_t op_imm(input logic [2:0] f3, input int rd, input int rs1,
                                           input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0010011};
  endfunction

  function automatic rv_pkg::word_t op_reg(input logic [6:0] f7, input logic [2:0] f3,
                                           input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
  endfunction

  function automatic rv_pkg::word_t branch_insn(input logic [2:0] f3, input int rs1,
                                                input int rs2, input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_pkg::word_t jal_insn(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  function automatic rv_pkg::word_t jalr_insn(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b1100111};
  endfunction

  function automatic rv_pkg::word_t lui_insn(input int rd, input int imm20);
    return {imm20[19:0], rd[4:0], 7'b0110111};
  endfunction

  function automatic rv_pkg::word_t ecall_insn();
    return 32'h0000_0073;
  endfunction

  // integer ops selected by funct3 where alt picks sub and sra
  function automatic rv_pkg::word_t arith(input logic [2:0] f3, input logic alt,
                                          input rv_pkg::word_t a, input rv_pkg::word_t b);
    logic signed [31:0] sa;
    sa = $signed(a);
    case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: begin
        if (alt) begin
          return sa >>> b[4:0];
        end
        return a >> b[4:0];
      end
      3'd6: return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic add_entry(input rv_pkg::word_t pc, input rv_pkg::word_t insn,
                           input rv_pkg::cycle_status_e status, input logic we,
                           input rv_pkg::reg_addr_t rd, input rv_pkg::word_t data,
                           input logic halt_exp);
    trace_entry_t e;
    e.pc     = pc;
    e.insn   = insn;
    e.status = status;
    e.we     = we;
    e.rd     = rd;
    e.data   = data;
    e.halt   = halt_exp;
    exp_q.push_back(e);
  endtask

  // instruction-level model that yields one trace entry per writeback cycle
  task automatic build_expected();
    rv_pkg::word_t     regs [32];
    rv_pkg::word_t     pc;
    rv_pkg::word_t     insn;
    rv_pkg::word_t     a;
    rv_pkg::word_t     b;
    rv_pkg::word_t     val;
    rv_pkg::word_t     next_pc;
    rv_pkg::word_t     imm_i;
    rv_pkg::word_t     imm_b;
    rv_pkg::word_t     imm_j;
    rv_pkg::reg_addr_t rd;
    logic [2:0]        f3;
    logic [6:0]        f7;
    logic              writes;
    logic              bad;
    logic              jump;
    logic              done;
    int                steps;
    exp_q.delete();
    for (int r = 0; r < 32; r++) begin
      regs[r] = '0;
    end
    pc    = '0;
    steps = 0;
    done  = 1'b0;
    while (!done) begin
      if (pc[31:2] >= prog.size()) begin
        fail_with_reason("reference model ran past the end of the program");
      end
      insn    = prog[pc[31:2]];
      rd      = insn[11:7];
      f3      = insn[14:12];
      f7      = insn[31:25];
      a       = regs[insn[19:15]];
      b       = regs[insn[24:20]];
      imm_i   = {{20{insn[31]}}, insn[31:20]};
      imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
      imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
      val     = '0;
      writes  = 1'b0;
      bad     = 1'b0;
      jump    = 1'b0;
      next_pc = pc + 32'd4;
      case (insn[6:0])
        7'b0110111: begin
          val    = {insn[31:12], 12'h000};
          writes = 1'b1;
        end
        7'b0010011: begin
          if ((f3 == 3'd1 && f7 != 7'h00) ||
              (f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20)) begin
            bad = 1'b1;
          end else begin
            val    = arith(f3, f3 == 3'd5 && f7 == 7'h20, a, imm_i);
            writes = 1'b1;
          end
        end
        7'b0110011: begin
          if (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))) begin
            val    = arith(f3, f7 == 7'h20, a, b);
            writes = 1'b1;
          end else begin
            bad = 1'b1;
          end
        end
        7'b1100011: begin
          case (f3)
            3'd0: jump = (a == b);
            3'd1: jump = (a != b);
            3'd4: jump = ($signed(a) < $signed(b));
            3'd5: jump = ($signed(a) >= $signed(b));
            3'd6: jump = (a < b);
            3'd7: jump = (a >= b);
            default: bad = 1'b1;
          endcase
          if (jump) begin
            next_pc = pc + imm_b;
          end
        end
        7'b1101111: begin
          val     = pc + 32'd4;
          writes  = 1'b1;
          jump    = 1'b1;
          next_pc = pc + imm_j;
        end
        7'b1100111: begin
          if (f3 == 3'd0) begin
            val     = pc + 32'd4;
            writes  = 1'b1;
            jump    = 1'b1;
            next_pc = (a + imm_i) & ~32'd1;
          end else begin
            bad = 1'b1;
          end
        end
        7'b1110011: begin
          if (insn == ecall_insn()) begin
            done = 1'b1;
          end else begin
            bad = 1'b1;
          end
        end
        default: bad = 1'b1;
      endcase
      if (bad) begin
        add_entry('0, '0, rv_pkg::no_stall, 1'b0, '0, '0, 1'b0);
      end else begin
        add_entry(pc, insn, rv_pkg::no_stall, writes && rd != 0, rd, val, done);
        if (writes && rd != 0) begin
          regs[rd] = val;
        end
        if (jump) begin
          add_entry('0, '0, rv_pkg::taken_branch, 1'b0, '0, '0, 1'b0);
          add_entry('0, '0, rv_pkg::taken_branch, 1'b0, '0, '0, 1'b0);
        end
      end
      pc = next_pc;
      steps++;
      if (steps > 100) begin
        fail_with_reason("reference model did not reach ecall within 100 instructions");
      end
    end
  endtask

  // program is written while rst is high and reset is held 5 more cycles after that
  task automatic load_and_reset();
    if (prog.size() > rv_pkg::imem_words) begin
      fail_with_reason("program does not fit in the instruction memory");
    end
    @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < prog.size(); i++) begin
      @(posedge clk);
      imem_we   <= 1'b1;
      imem_addr <= i[rv_pkg::imem_addr_w-1:0];
      imem_data <= prog[i];
    end
    @(posedge clk);
    imem_we <= 1'b0;
    repeat (5) begin
      @(negedge clk);
      check_status("trace_status", rv_pkg::reset, trace_status);
      check_bit("trace_we", 1'b0, trace_we);
      check_bit("halt", 1'b0, halt);
      @(posedge clk);
    end
    rst <= 1'b0;
  endtask

  // one expected entry per clock cycle once the reset cycles have passed
  task automatic compare_trace();
    trace_entry_t e;
    int           n_reset;
    n_reset = 0;
    @(negedge clk);
    while (trace_status == rv_pkg::reset) begin
      check_bit("trace_we", 1'b0, trace_we);
      check_bit("halt", 1'b0, halt);
      n_reset++;
      if (n_reset > 4) begin
        fail_with_reason("trace stayed in reset status longer than four cycles after reset");
      end
      @(negedge clk);
    end
    if (n_reset != 4) begin
      fail_with_reason("first instruction reached the trace too early after reset");
    end
    for (int i = 0; i < exp_q.size(); i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      e = exp_q[i];
      check_status("trace_status", e.status, trace_status);
      check_bit("trace_we", e.we, trace_we);
      check_bit("halt", e.halt, halt);
      if (e.status == rv_pkg::no_stall) begin
        check_word("trace_pc", e.pc, trace_pc);
        check_word("trace_insn", e.insn, trace_insn);
      end
      if (e.we) begin
        check_reg("trace_rd", e.rd, trace_rd);
        check_word("trace_data", e.data, trace_data);
      end
    end
  endtask

  task automatic run_program();
    load_and_reset();
    build_expected();
    compare_trace();
  endtask

  task automatic test_reset_trace();
    prog.delete();
    prog.push_back(op_imm(3'd0, 1, 0, 1));
    prog.push_back(op_imm(3'd0, 2, 1, 2));
    prog.push_back(op_imm(3'd0, 3, 2, 3));
    prog.push_back(ecall_insn());
    run_program();
  endtask

  task automatic test_reg_imm();
    prog.delete();
    prog.push_back(op_imm(3'd0, 1, 0, -5));
    prog.push_back(op_imm(3'd2, 2, 1, -4));
    prog.push_back(op_imm(3'd3, 3, 1, 5));
    prog.push_back(op_imm(3'd4, 4, 1, -1));
    prog.push_back(op_imm(3'd6, 5, 0, 'h7f0));
    prog.push_back(op_imm(3'd7, 6, 1, 'h0ff));
    prog.push_back(op_imm(3'd1, 7, 1, 4));
    prog.push_back(op_imm(3'd5, 8, 1, 28));
    // srai carries funct7 0100000 in the upper immediate bits
    prog.push_back(op_imm(3'd5, 9, 1, 'h401));
    prog.push_back(lui_insn(10, 'habcde));
    prog.push_back(op_imm(3'd0, 0, 1, 7));
    prog.push_back(op_imm(3'd0, 11, 10, -1));
    prog.push_back(ecall_insn());
    run_program();
  endtask

  task automatic test_reg_reg_forwarding();
    prog.delete();
    prog.push_back(op_imm(3'd0, 1, 0, 100));
    prog.push_back(op_imm(3'd0, 2, 0, -7));
    prog.push_back(op_reg(7'h00, 3'd0, 3, 1, 2));
    prog.push_back(op_reg(7'h20, 3'd0, 4, 3, 1));
    prog.push_back(op_reg(7'h00, 3'd4, 5, 4, 3));
    prog.push_back(op_reg(7'h00, 3'd6, 6, 5, 4));
    prog.push_back(op_reg(7'h00, 3'd7, 7, 6, 3));
    prog.push_back(op_reg(7'h00, 3'd1, 8, 1, 2));
    prog.push_back(op_reg(7'h00, 3'd5, 9, 8, 1));
    prog.push_back(op_reg(7'h20, 3'd5, 10, 2, 1));
    prog.push_back(op_reg(7'h00, 3'd2, 11, 2, 1));
    prog.push_back(op_reg(7'h00, 3'd3, 12, 2, 1));
    prog.push_back(op_reg(7'h00, 3'd0, 1, 1, 1));
    prog.push_back(op_reg(7'h00, 3'd0, 13, 1, 1));
    // the newer of two writes to the same rd must win
    prog.push_back(op_imm(3'd0, 14, 0, 1));
    prog.push_back(op_imm(3'd0, 14, 0, 2));
    prog.push_back(op_reg(7'h00, 3'd0, 15, 14, 0));
    prog.push_back(ecall_insn());
    run_program();
  endtask

  task automatic test_branches_jumps();
    prog.delete();
    prog.push_back(op_imm(3'd0, 1, 0, 5));
    prog.push_back(op_imm(3'd0, 2, 0, -3));
    prog.push_back(branch_insn(3'd0, 1, 2, 8));
    prog.push_back(branch_insn(3'd4, 2, 1, 8));
    prog.push_back(op_imm(3'd0, 3, 0, 99));
    prog.push_back(branch_insn(3'd7, 2, 1, 8));
    prog.push_back(op_imm(3'd0, 3, 0, 98));
    prog.push_back(jal_insn(4, 12));
    prog.push_back(op_imm(3'd0, 3, 0, 97));
    prog.push_back(op_imm(3'd0, 3, 0, 96));
    // odd jalr target whose bit 0 must be dropped
    prog.push_back(jalr_insn(5, 4, 17));
    prog.push_back(op_imm(3'd0, 3, 0, 95));
    prog.push_back(branch_insn(3'd1, 1, 1, 8));
    prog.push_back(branch_insn(3'd5, 2, 1, 8));
    prog.push_back(branch_insn(3'd6, 1, 2, 8));
    prog.push_back(op_imm(3'd0, 3, 0, 94));
    prog.push_back(op_reg(7'h00, 3'd0, 6, 4, 5));
    prog.push_back(ecall_insn());
    run_program();
  endtask

  task automatic test_illegal_halt();
    prog.delete();
    prog.push_back(op_imm(3'd0, 1, 0, 3));
    // fence
    prog.push_back(32'h0ff0_000f);
    prog.push_back(32'hffff_ffff);
    // mul from the M extension
    prog.push_back(op_reg(7'h01, 3'd0, 3, 1, 1));
    prog.push_back(branch_insn(3'd2, 1, 1, 8));
    // x3 was cleared by reset and the mul above must not write it
    prog.push_back(op_reg(7'h00, 3'd0, 4, 3, 1));
    prog.push_back(op_imm(3'd0, 2, 1, 4));
    prog.push_back(ecall_insn());
    run_program();
  endtask

  // 200 cycles for each of the five tests
  initial begin
    repeat (5 * 200) @(posedge clk);
    $display("[ERROR] run timed out after %0d cycles", 5 * 200);
    stop_failed();
  end

  initial begin
    rst       = 1'b1;
    imem_we   = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    test_reset_trace();
    test_reg_imm();
    test_reg_reg_forwarding();
    test_branches_jumps();
    test_illegal_halt();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== sim.f ====
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/reg_file.sv
hw/execute_alu.sv
hw/pipe_control.sv
hw/riscv_core.sv
test/tb_clock.sv
test/tb_riscv_core.sv
